/* include/rv32i_decode_cfg.svh */
// RV32I decoder configuration: word, register-address and byte-enable widths
`ifndef RV32I_DECODE_CFG_SVH
`define RV32I_DECODE_CFG_SVH

// Instruction and immediate width
`define XLEN_W 32

// Register file address width
`define REG_ADDR_W 5

// One enable per data-memory byte lane
`define DM_BE_W 4

`endif

/* logic/rv32i_decode_pkg.sv */
// RV32I decoder types shared by the decode stages and the top level
`default_nettype none

package rv32i_decode_pkg;

   // Opcode category from inst[6:2]
   typedef enum logic [3:0] {
      CLS_NONE     = 4'd0,
      CLS_LOAD     = 4'd1,
      CLS_MISC_MEM = 4'd2,
      CLS_OP_IMM   = 4'd3,
      CLS_AUIPC    = 4'd4,
      CLS_STORE    = 4'd5,
      CLS_OP       = 4'd6,
      CLS_LUI      = 4'd7,
      CLS_BRANCH   = 4'd8,
      CLS_JALR     = 4'd9,
      CLS_JAL      = 4'd10,
      CLS_SYSTEM   = 4'd11,
      CLS_UNSUP    = 4'd12
   } op_class_t;

   // One-hot immediate format, bit order I U R J B S
   typedef enum logic [5:0] {
      FMT_NONE = 6'b000000,
      FMT_I    = 6'b100000,
      FMT_U    = 6'b010000,
      FMT_R    = 6'b001000,
      FMT_J    = 6'b000100,
      FMT_B    = 6'b000010,
      FMT_S    = 6'b000001
   } imm_fmt_t;

   // ALU operation, encodings fixed for the execute stage
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLL  = 4'd2,
      ALU_SLT  = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SRL  = 4'd5,
      ALU_SRA  = 4'd6,
      ALU_OR   = 4'd7,
      ALU_AND  = 4'd8,
      ALU_UNKN = 4'd15
   } alu_op_t;

   typedef enum logic {
      OP1_RS1 = 1'b0,
      OP1_PC  = 1'b1
   } op1_sel_t;

   typedef enum logic [1:0] {
      OP2_RS2  = 2'd0,
      OP2_IMM  = 2'd1,
      OP2_UNKN = 2'd3
   } op2_sel_t;

endpackage

`default_nettype wire

/* logic/inst_fields_if.sv */
// Decoded instruction fields from the extraction stage to the decode stages
`default_nettype none
`include "rv32i_decode_cfg.svh"

interface inst_fields_if
   import rv32i_decode_pkg::*;
();

   op_class_t              op_class;
   logic [2:0]             funct3;
   logic [6:0]             funct7;
   // inst[30], selects SUB and arithmetic shifts
   logic                   shamt_hint;
   logic [`XLEN_W-1:0]     immediate;

   modport src (output op_class, funct3, funct7, shamt_hint, immediate);

   modport dst (input op_class, funct3, funct7, shamt_hint, immediate);

endinterface

`default_nettype wire

/* logic/inst_field_decode.sv */
// RV32I field extraction: opcode class, immediate format, immediate and registers
`default_nettype none
`include "rv32i_decode_cfg.svh"

module inst_field_decode
   import rv32i_decode_pkg::*;
(
   input  wire                        clk,
   input  wire                        FD_reset,
   input  wire [`XLEN_W-1:0]          inst,
   output logic [`REG_ADDR_W-1:0]     a_rs1,
   output logic [`REG_ADDR_W-1:0]     a_rs2,
   output logic [`REG_ADDR_W-1:0]     a_rd,
   inst_fields_if.src                 fields,
   output logic                       exception_unsupported_category
);

   op_class_t             cls;
   imm_fmt_t              fmt;
   logic                  shamt_form;
   logic [`XLEN_W-1:0]    imm;

   // Blank the whole decode while in reset
   always_comb begin
      if (!FD_reset) begin
         cls = CLS_NONE;
      end else begin
         case (inst[6:2])
            5'b00000: cls = CLS_LOAD;
            5'b00011: cls = CLS_MISC_MEM;
            5'b00100: cls = CLS_OP_IMM;
            5'b00101: cls = CLS_AUIPC;
            5'b01000: cls = CLS_STORE;
            5'b01100: cls = CLS_OP;
            5'b01101: cls = CLS_LUI;
            5'b11000: cls = CLS_BRANCH;
            5'b11001: cls = CLS_JALR;
            5'b11011: cls = CLS_JAL;
            5'b11100: cls = CLS_SYSTEM;
            default:  cls = CLS_UNSUP;
         endcase
      end
   end

   always_comb begin
      case (cls)
         CLS_LOAD, CLS_MISC_MEM, CLS_OP_IMM, CLS_JALR, CLS_SYSTEM: fmt = FMT_I;
         CLS_LUI, CLS_AUIPC: fmt = FMT_U;
         CLS_OP:             fmt = FMT_R;
         CLS_JAL:            fmt = FMT_J;
         CLS_BRANCH:         fmt = FMT_B;
         CLS_STORE:          fmt = FMT_S;
         default:            fmt = FMT_NONE;
      endcase
   end

   // SLLI/SRLI/SRAI carry a zero-extended shift amount
   assign shamt_form = (cls == CLS_OP_IMM) && (inst[13:12] == 2'b01);

   always_comb begin
      case (fmt)
         FMT_I: imm = shamt_form ? {27'b0, inst[24:20]} : {{21{inst[31]}}, inst[30:20]};
         FMT_U: imm = {inst[31:12], 12'b0};
         FMT_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
         FMT_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
         FMT_S: imm = {{21{inst[31]}}, inst[30:25], inst[11:8], inst[7]};
         default: imm = '0;
      endcase
   end

   // LUI adds its immediate to x0
   assign a_rs1 = (cls == CLS_LUI) ? '0 : inst[19:15];
   assign a_rs2 = inst[24:20];
   assign a_rd  = inst[11:7];

   assign fields.op_class   = cls;
   assign fields.funct3     = inst[14:12];
   assign fields.funct7     = inst[31:25];
   assign fields.shamt_hint = inst[30];
   assign fields.immediate  = imm;

   assign exception_unsupported_category = (cls == CLS_UNSUP);

   // Every recognized class has exactly one immediate format
   a_fmt_onehot: assert property (@(posedge clk)
      !(cls inside {CLS_NONE, CLS_UNSUP}) |-> $onehot(fmt));

endmodule

`default_nettype wire

/* logic/alu_ctrl_decode.sv */
// RV32I ALU control decode: operation, operand selects and signedness
`default_nettype none

module alu_ctrl_decode
   import rv32i_decode_pkg::*;
(
   inst_fields_if.dst     fields,
   output logic           alu_is_signed,
   output op1_sel_t       aluop1_sel,
   output op2_sel_t       aluop2_sel,
   output alu_op_t        alu_op,
   output logic           alu_regwrite
);

   logic is_reg_op;

   assign is_reg_op = (fields.op_class == CLS_OP);

   always_comb begin
      // Idle ALU defaults
      alu_is_signed = 1'b1;
      aluop1_sel    = OP1_RS1;
      aluop2_sel    = OP2_UNKN;
      alu_op        = ALU_UNKN;
      alu_regwrite  = 1'b0;

      case (fields.op_class)
         CLS_OP_IMM, CLS_OP: begin
            alu_regwrite = 1'b1;
            aluop2_sel   = is_reg_op ? OP2_RS2 : OP2_IMM;
            case (fields.funct3)
               // Only the register form has SUB
               3'b000: alu_op = (is_reg_op && fields.shamt_hint) ? ALU_SUB : ALU_ADD;
               3'b001: alu_op = ALU_SLL;
               3'b010: alu_op = ALU_SLT;
               3'b011: begin
                  alu_op        = ALU_SLT;
                  alu_is_signed = 1'b0;
               end
               3'b100: alu_op = ALU_XOR;
               3'b101: alu_op = fields.shamt_hint ? ALU_SRA : ALU_SRL;
               3'b110: alu_op = ALU_OR;
               default: alu_op = ALU_AND;
            endcase
         end
         CLS_LUI, CLS_AUIPC: begin
            alu_regwrite = 1'b1;
            alu_op       = ALU_ADD;
            aluop2_sel   = OP2_IMM;
            if (fields.op_class == CLS_AUIPC) begin
               aluop1_sel = OP1_PC;
            end
         end
         // Link address add, operands come from the core
         CLS_JAL, CLS_JALR: begin
            alu_regwrite = 1'b1;
            alu_op       = ALU_ADD;
            aluop2_sel   = OP2_RS2;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* logic/mem_access_decode.sv */
// RV32I memory access decode: byte enables, signedness and misalignment
`default_nettype none
`include "rv32i_decode_cfg.svh"

module mem_access_decode
   import rv32i_decode_pkg::*;
(
   input  wire                      clk,
   input  wire [1:0]                aluout_1_0,
   inst_fields_if.dst               fields,
   output logic [`DM_BE_W-1:0]      dm_be,
   output logic                     dm_we,
   output logic                     mem_is_signed,
   output logic                     load_regwrite,
   output logic                     mem_illegal,
   output logic                     exception_load_misaligned,
   output logic                     exception_store_misaligned
);

   logic                   is_load;
   logic                   is_store;
   logic                   load_ok;
   logic                   store_ok;
   logic [`DM_BE_W-1:0]    acc_be;
   logic                   acc_misaligned;

   assign is_load  = (fields.op_class == CLS_LOAD);
   assign is_store = (fields.op_class == CLS_STORE);

   // LB LH LW LBU LHU are the only loads, SB SH SW the only stores
   assign load_ok  = (fields.funct3[1:0] != 2'b11) && (fields.funct3 != 3'b110);
   assign store_ok = (fields.funct3 <= 3'b010);

   // Lanes by access size, misaligned accesses enable none
   always_comb begin
      acc_be         = '0;
      acc_misaligned = 1'b0;
      case (fields.funct3[1:0])
         2'b00: acc_be = {{(`DM_BE_W-1){1'b0}}, 1'b1} << aluout_1_0;
         2'b01: begin
            acc_misaligned = aluout_1_0[0];
            if (!aluout_1_0[0]) begin
               acc_be = aluout_1_0[1] ? 4'b1100 : 4'b0011;
            end
         end
         2'b10: begin
            acc_misaligned = |aluout_1_0;
            if (aluout_1_0 == 2'b00) begin
               acc_be = '1;
            end
         end
         default: ;
      endcase
   end

   assign dm_we         = is_store;
   assign dm_be         = ((is_load && load_ok) || (is_store && store_ok)) ? acc_be : '0;
   assign mem_is_signed = is_load && (fields.funct3[2:1] == 2'b00);
   assign load_regwrite = is_load;
   assign mem_illegal   = (is_load && !load_ok) || (is_store && !store_ok);

   assign exception_load_misaligned  = is_load && load_ok && acc_misaligned;
   assign exception_store_misaligned = is_store && store_ok && acc_misaligned;

   // A faulting access must not touch memory
   a_no_lanes_on_fault: assert property (@(posedge clk)
      (exception_load_misaligned || exception_store_misaligned) |-> (dm_be == '0));

endmodule

`default_nettype wire

/* logic/flow_sys_decode.sv */
// RV32I control flow and system decode: jumps, branches, MRET, CSR and traps
`default_nettype none

module flow_sys_decode
   import rv32i_decode_pkg::*;
(
   input  wire            clk,
   inst_fields_if.dst     fields,
   output logic           jump,
   output logic           link,
   output logic           jr,
   output logic           br,
   output logic           pc_update,
   output logic           pc_mepc,
   output logic           csr_read,
   output logic           csr_write,
   output logic           csr_set,
   output logic           csr_clear,
   output logic           csr_imm,
   output logic           csr_regwrite,
   output logic           flow_illegal,
   output logic           exception_ecall,
   output logic           exception_ebreak
);

   always_comb begin
      jump             = 1'b0;
      link             = 1'b0;
      jr               = 1'b0;
      br               = 1'b0;
      pc_update        = 1'b0;
      pc_mepc          = 1'b0;
      csr_read         = 1'b0;
      csr_write        = 1'b0;
      csr_set          = 1'b0;
      csr_clear        = 1'b0;
      csr_imm          = 1'b0;
      csr_regwrite     = 1'b0;
      flow_illegal     = 1'b0;
      exception_ecall  = 1'b0;
      exception_ebreak = 1'b0;

      case (fields.op_class)
         CLS_JAL: begin
            jump = 1'b1;
            link = 1'b1;
         end
         CLS_JALR: begin
            jr   = 1'b1;
            link = 1'b1;
         end
         CLS_BRANCH: begin
            // Comparator picks the condition, 010 and 011 are reserved
            br           = 1'b1;
            flow_illegal = (fields.funct3[2:1] == 2'b01);
         end
         CLS_SYSTEM: begin
            if (fields.funct3 == 3'b000) begin
               case (fields.funct7)
                  // imm[0] tells EBREAK from ECALL
                  7'b0000000: begin
                     exception_ecall  = ~fields.immediate[0];
                     exception_ebreak = fields.immediate[0];
                  end
                  7'b0011000: begin
                     pc_update = 1'b1;
                     pc_mepc   = 1'b1;
                  end
                  default: flow_illegal = 1'b1;
               endcase
            end else if (fields.funct3 == 3'b100) begin
               flow_illegal = 1'b1;
            end else begin
               csr_read     = 1'b1;
               csr_regwrite = 1'b1;
               csr_imm      = fields.funct3[2];
               csr_write    = (fields.funct3[1:0] == 2'b01);
               csr_set      = (fields.funct3[1:0] == 2'b10);
               csr_clear    = (fields.funct3[1:0] == 2'b11);
            end
         end
         default: ;
      endcase
   end

   // CSR update kinds are mutually exclusive
   a_csr_op_exclusive: assert property (@(posedge clk)
      $onehot0({csr_write, csr_set, csr_clear}));

endmodule

`default_nettype wire

/* logic/instruction_decoder.sv */
// RV32I instruction decoder top, merges stage results into writeback and faults
`default_nettype none
`include "rv32i_decode_cfg.svh"

module instruction_decoder
   import rv32i_decode_pkg::*;
(
   input  wire                        clk,
   input  wire                        FD_reset,
   input  wire [`XLEN_W-1:0]          inst,
   input  wire [1:0]                  aluout_1_0,
   output logic [`XLEN_W-1:0]         immediate,
   output logic                       alu_is_signed,
   output op1_sel_t                   aluop1_sel,
   output op2_sel_t                   aluop2_sel,
   output alu_op_t                    alu_op,
   output logic                       pc_update,
   output logic                       pc_mepc,
   output logic                       regwrite,
   output logic                       jump,
   output logic                       link,
   output logic                       jr,
   output logic                       br,
   output logic [`DM_BE_W-1:0]        dm_be,
   output logic                       dm_we,
   output logic                       mem_is_signed,
   output logic                       csr_read,
   output logic                       csr_write,
   output logic                       csr_set,
   output logic                       csr_clear,
   output logic                       csr_imm,
   output logic [`REG_ADDR_W-1:0]     a_rs1,
   output logic [`REG_ADDR_W-1:0]     a_rs2,
   output logic [`REG_ADDR_W-1:0]     a_rd,
   output logic [2:0]                 funct3,
   output logic [6:0]                 funct7,
   output logic                       exception_unsupported_category,
   output logic                       exception_illegal_instruction,
   output logic                       exception_load_misaligned,
   output logic                       exception_store_misaligned,
   output logic                       exception_ecall,
   output logic                       exception_ebreak
);

   // Writeback requests and illegal flags from the stages
   logic alu_regwrite;
   logic load_regwrite;
   logic csr_regwrite;
   logic mem_illegal;
   logic flow_illegal;

   inst_fields_if fields_bus ();

   inst_field_decode u_fields (
      .clk                            (clk),
      .FD_reset                       (FD_reset),
      .inst                           (inst),
      .a_rs1                          (a_rs1),
      .a_rs2                          (a_rs2),
      .a_rd                           (a_rd),
      .fields                         (fields_bus.src),
      .exception_unsupported_category (exception_unsupported_category)
   );

   alu_ctrl_decode u_alu (
      .fields        (fields_bus.dst),
      .alu_is_signed (alu_is_signed),
      .aluop1_sel    (aluop1_sel),
      .aluop2_sel    (aluop2_sel),
      .alu_op        (alu_op),
      .alu_regwrite  (alu_regwrite)
   );

   mem_access_decode u_mem (
      .clk                        (clk),
      .aluout_1_0                 (aluout_1_0),
      .fields                     (fields_bus.dst),
      .dm_be                      (dm_be),
      .dm_we                      (dm_we),
      .mem_is_signed              (mem_is_signed),
      .load_regwrite              (load_regwrite),
      .mem_illegal                (mem_illegal),
      .exception_load_misaligned  (exception_load_misaligned),
      .exception_store_misaligned (exception_store_misaligned)
   );

   flow_sys_decode u_flow (
      .clk              (clk),
      .fields           (fields_bus.dst),
      .jump             (jump),
      .link             (link),
      .jr               (jr),
      .br               (br),
      .pc_update        (pc_update),
      .pc_mepc          (pc_mepc),
      .csr_read         (csr_read),
      .csr_write        (csr_write),
      .csr_set          (csr_set),
      .csr_clear        (csr_clear),
      .csr_imm          (csr_imm),
      .csr_regwrite     (csr_regwrite),
      .flow_illegal     (flow_illegal),
      .exception_ecall  (exception_ecall),
      .exception_ebreak (exception_ebreak)
   );

   assign immediate = fields_bus.immediate;
   assign funct3    = fields_bus.funct3;
   assign funct7    = fields_bus.funct7;

   assign exception_illegal_instruction = mem_illegal | flow_illegal;

   // Any fault cancels the writeback
   assign regwrite = (alu_regwrite | load_regwrite | csr_regwrite)
                     & ~(exception_unsupported_category
                         | exception_illegal_instruction
                         | exception_load_misaligned
                         | exception_store_misaligned);

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Testbench clock source, free running square wave with a fixed period
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD = 40
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_instruction_decoder.sv */
// Testbench for the RV32I instruction decoder against a reference decode
`default_nettype none
`include "rv32i_decode_cfg.svh"

module tb_instruction_decoder
   import rv32i_decode_pkg::*;
;

   // Opcode values of inst[6:2]
   localparam logic [4:0] opc_load     = 5'h00;
   localparam logic [4:0] opc_misc_mem = 5'h03;
   localparam logic [4:0] opc_op_imm   = 5'h04;
   localparam logic [4:0] opc_auipc    = 5'h05;
   localparam logic [4:0] opc_store    = 5'h08;
   localparam logic [4:0] opc_op       = 5'h0C;
   localparam logic [4:0] opc_lui      = 5'h0D;
   localparam logic [4:0] opc_branch   = 5'h18;
   localparam logic [4:0] opc_jalr     = 5'h19;
   localparam logic [4:0] opc_jal      = 5'h1B;
   localparam logic [4:0] opc_system   = 5'h1C;

   typedef struct packed {
      logic [`XLEN_W-1:0]     immediate;
      logic                   alu_is_signed;
      op1_sel_t               aluop1_sel;
      op2_sel_t               aluop2_sel;
      alu_op_t                alu_op;
      logic                   pc_update;
      logic                   pc_mepc;
      logic                   regwrite;
      logic                   jump;
      logic                   link;
      logic                   jr;
      logic                   br;
      logic [`DM_BE_W-1:0]    dm_be;
      logic                   dm_we;
      logic                   mem_is_signed;
      logic                   csr_read;
      logic                   csr_write;
      logic                   csr_set;
      logic                   csr_clear;
      logic                   csr_imm;
      logic [`REG_ADDR_W-1:0] a_rs1;
      logic [`REG_ADDR_W-1:0] a_rs2;
      logic [`REG_ADDR_W-1:0] a_rd;
      logic [2:0]             funct3;
      logic [6:0]             funct7;
      logic                   exc_unsup;
      logic                   exc_illegal;
      logic                   exc_lmis;
      logic                   exc_smis;
      logic                   exc_ecall;
      logic                   exc_ebreak;
   } dec_t;

   logic                      clk;
   logic                      FD_reset;
   logic [`XLEN_W-1:0]        inst;
   logic [1:0]                aluout_1_0;
   logic [`XLEN_W-1:0]        immediate;
   logic                      alu_is_signed;
   logic                      aluop1_sel;
   logic [1:0]                aluop2_sel;
   logic [3:0]                alu_op;
   logic                      pc_update;
   logic                      pc_mepc;
   logic                      regwrite;
   logic                      jump;
   logic                      link;
   logic                      jr;
   logic                      br;
   logic [`DM_BE_W-1:0]       dm_be;
   logic                      dm_we;
   logic                      mem_is_signed;
   logic                      csr_read;
   logic                      csr_write;
   logic                      csr_set;
   logic                      csr_clear;
   logic                      csr_imm;
   logic [`REG_ADDR_W-1:0]    a_rs1;
   logic [`REG_ADDR_W-1:0]    a_rs2;
   logic [`REG_ADDR_W-1:0]    a_rd;
   logic [2:0]                funct3;
   logic [6:0]                funct7;
   logic                      exception_unsupported_category;
   logic                      exception_illegal_instruction;
   logic                      exception_load_misaligned;
   logic                      exception_store_misaligned;
   logic                      exception_ecall;
   logic                      exception_ebreak;

   dec_t                      exp_dec;
   int                        n_checked = 0;

   tb_clock_gen #(.PERIOD(40)) u_clk (.clk(clk));

   instruction_decoder uut (.*);

   // Expected decode of one instruction at one address offset
   function automatic dec_t ref_decode(input logic rst_n, input logic [31:0] i,
                                       input logic [1:0] off);
      dec_t       d;
      logic [4:0] opc;
      logic [2:0] f3;
      logic [3:0] lanes;
      logic       misaligned;
      logic       legal;
      logic       wb_req;
      logic [31:0] imm_i;
      opc = i[6:2];
      f3 = i[14:12];
      imm_i = {{20{i[31]}}, i[31:20]};
      wb_req = 1'b0;
      d = '0;
      d.alu_is_signed = 1'b1;
      d.aluop1_sel = OP1_RS1;
      d.aluop2_sel = OP2_UNKN;
      d.alu_op = ALU_UNKN;
      d.a_rs1 = i[19:15];
      d.a_rs2 = i[24:20];
      d.a_rd = i[11:7];
      d.funct3 = f3;
      d.funct7 = i[31:25];
      if (!rst_n) begin
         return d;
      end
      // Lanes and alignment by access width
      lanes = 4'b0000;
      misaligned = 1'b0;
      case (f3[1:0])
         2'b00: lanes = 4'b0001 << off;
         2'b01: begin
            misaligned = off[0];
            lanes = off[0] ? 4'b0000 : (off[1] ? 4'b1100 : 4'b0011);
         end
         2'b10: begin
            misaligned = (off != 2'b00);
            lanes = misaligned ? 4'b0000 : 4'b1111;
         end
         default: lanes = 4'b0000;
      endcase
      case (opc)
         opc_load: begin
            d.immediate = imm_i;
            legal = !(f3 inside {3'b011, 3'b110, 3'b111});
            wb_req = 1'b1;
            d.mem_is_signed = (f3 == 3'b000) || (f3 == 3'b001);
            d.dm_be = legal ? lanes : 4'b0000;
            d.exc_lmis = legal && misaligned;
            d.exc_illegal = !legal;
         end
         opc_store: begin
            d.immediate = {{20{i[31]}}, i[31:25], i[11:7]};
            legal = (f3 <= 3'b010);
            d.dm_we = 1'b1;
            d.dm_be = legal ? lanes : 4'b0000;
            d.exc_smis = legal && misaligned;
            d.exc_illegal = !legal;
         end
         opc_misc_mem: d.immediate = imm_i;
         opc_op_imm, opc_op: begin
            wb_req = 1'b1;
            d.aluop2_sel = (opc == opc_op) ? OP2_RS2 : OP2_IMM;
            if (opc == opc_op) begin
               d.immediate = '0;
            end else if (f3[1:0] == 2'b01) begin
               d.immediate = {27'b0, i[24:20]};
            end else begin
               d.immediate = imm_i;
            end
            case (f3)
               3'b000: d.alu_op = (opc == opc_op && i[30]) ? ALU_SUB : ALU_ADD;
               3'b001: d.alu_op = ALU_SLL;
               3'b010: d.alu_op = ALU_SLT;
               3'b011: begin
                  d.alu_op = ALU_SLT;
                  d.alu_is_signed = 1'b0;
               end
               3'b100: d.alu_op = ALU_XOR;
               3'b101: d.alu_op = i[30] ? ALU_SRA : ALU_SRL;
               3'b110: d.alu_op = ALU_OR;
               default: d.alu_op = ALU_AND;
            endcase
         end
         opc_lui, opc_auipc: begin
            wb_req = 1'b1;
            d.immediate = {i[31:12], 12'h000};
            d.alu_op = ALU_ADD;
            d.aluop2_sel = OP2_IMM;
            if (opc == opc_auipc) begin
               d.aluop1_sel = OP1_PC;
            end else begin
               d.a_rs1 = '0;
            end
         end
         opc_jal, opc_jalr: begin
            wb_req = 1'b1;
            d.alu_op = ALU_ADD;
            d.aluop2_sel = OP2_RS2;
            d.link = 1'b1;
            d.jump = (opc == opc_jal);
            d.jr = (opc == opc_jalr);
            if (opc == opc_jal) begin
               d.immediate = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            end else begin
               d.immediate = imm_i;
            end
         end
         opc_branch: begin
            d.immediate = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            d.br = 1'b1;
            d.exc_illegal = (f3 == 3'b010) || (f3 == 3'b011);
         end
         opc_system: begin
            d.immediate = imm_i;
            if (f3 == 3'b000) begin
               if (i[31:25] == 7'h00) begin
                  d.exc_ecall = !i[20];
                  d.exc_ebreak = i[20];
               end else if (i[31:25] == 7'h18) begin
                  d.pc_update = 1'b1;
                  d.pc_mepc = 1'b1;
               end else begin
                  d.exc_illegal = 1'b1;
               end
            end else if (f3 == 3'b100) begin
               d.exc_illegal = 1'b1;
            end else begin
               wb_req = 1'b1;
               d.csr_read = 1'b1;
               // CSRRWI, CSRRSI and CSRRCI
               d.csr_imm = (f3 inside {3'b101, 3'b110, 3'b111});
               d.csr_write = (f3 inside {3'b001, 3'b101});
               d.csr_set = (f3 inside {3'b010, 3'b110});
               d.csr_clear = (f3 inside {3'b011, 3'b111});
            end
         end
         default: d.exc_unsup = 1'b1;
      endcase
      d.regwrite = wb_req && !(d.exc_unsup || d.exc_illegal || d.exc_lmis || d.exc_smis);
      return d;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
      end
   endtask

   // Random word with the given opcode, funct3 and funct7
   function automatic logic [31:0] make_inst(input logic [4:0] opc, input logic [2:0] f3,
                                             input logic [6:0] f7);
      logic [31:0] w;
      w = $urandom;
      w[31:25] = f7;
      w[14:12] = f3;
      w[6:0] = {opc, 2'b11};
      return w;
   endfunction

   // Apply one instruction and wait until it has been compared
   task automatic drive(input logic [31:0] word, input logic [1:0] off);
      int start;
      int waited;
      start = n_checked;
      waited = 0;
      inst <= word;
      aluout_1_0 <= off;
      @(posedge clk);
      while (n_checked == start) begin
         if (waited == 4) begin
            abort_run("timeout, no comparison after a new instruction was applied");
         end
         @(posedge clk);
         waited++;
      end
   endtask

   // Outputs are stable half a cycle after the rising edge
   initial begin
      @(posedge clk);
      forever begin
         @(negedge clk);
         exp_dec = ref_decode(FD_reset, inst, aluout_1_0);
         check_value("immediate", immediate, exp_dec.immediate);
         check_value("alu_is_signed", alu_is_signed, exp_dec.alu_is_signed);
         check_value("aluop1_sel", aluop1_sel, exp_dec.aluop1_sel);
         check_value("aluop2_sel", aluop2_sel, exp_dec.aluop2_sel);
         check_value("alu_op", alu_op, exp_dec.alu_op);
         check_value("pc_update", pc_update, exp_dec.pc_update);
         check_value("pc_mepc", pc_mepc, exp_dec.pc_mepc);
         check_value("regwrite", regwrite, exp_dec.regwrite);
         check_value("jump", jump, exp_dec.jump);
         check_value("link", link, exp_dec.link);
         check_value("jr", jr, exp_dec.jr);
         check_value("br", br, exp_dec.br);
         check_value("dm_be", dm_be, exp_dec.dm_be);
         check_value("dm_we", dm_we, exp_dec.dm_we);
         check_value("mem_is_signed", mem_is_signed, exp_dec.mem_is_signed);
         check_value("csr_read", csr_read, exp_dec.csr_read);
         check_value("csr_write", csr_write, exp_dec.csr_write);
         check_value("csr_set", csr_set, exp_dec.csr_set);
         check_value("csr_clear", csr_clear, exp_dec.csr_clear);
         check_value("csr_imm", csr_imm, exp_dec.csr_imm);
         check_value("a_rs1", a_rs1, exp_dec.a_rs1);
         check_value("a_rs2", a_rs2, exp_dec.a_rs2);
         check_value("a_rd", a_rd, exp_dec.a_rd);
         check_value("funct3", funct3, exp_dec.funct3);
         check_value("funct7", funct7, exp_dec.funct7);
         check_value("exception_unsupported_category", exception_unsupported_category,
                     exp_dec.exc_unsup);
         check_value("exception_illegal_instruction", exception_illegal_instruction,
                     exp_dec.exc_illegal);
         check_value("exception_load_misaligned", exception_load_misaligned,
                     exp_dec.exc_lmis);
         check_value("exception_store_misaligned", exception_store_misaligned,
                     exp_dec.exc_smis);
         check_value("exception_ecall", exception_ecall, exp_dec.exc_ecall);
         check_value("exception_ebreak", exception_ebreak, exp_dec.exc_ebreak);
         n_checked = n_checked + 1;
      end
   end

   initial begin
      logic [31:0] r;
      logic [31:0] w;
      int          k;
      int          f;
      int          o;
      FD_reset = 1'b0;
      inst = '0;
      aluout_1_0 = 2'b00;
      r = $urandom(68398);
      @(posedge clk);
      // Random instructions while the decode is blanked
      for (k = 0; k < 3; k++) begin
         r = $urandom;
         drive($urandom, r[1:0]);
      end
      FD_reset <= 1'b1;
      // Both funct7 forms of every ALU funct3
      for (f = 0; f < 8; f++) begin
         r = $urandom;
         drive(make_inst(opc_op, f[2:0], 7'h00), r[1:0]);
         drive(make_inst(opc_op, f[2:0], 7'h20), r[1:0]);
         drive(make_inst(opc_op_imm, f[2:0], 7'h00), r[3:2]);
         drive(make_inst(opc_op_imm, f[2:0], 7'h20), r[3:2]);
         drive(make_inst(opc_lui, f[2:0], r[14:8]), r[5:4]);
         drive(make_inst(opc_auipc, f[2:0], r[22:16]), r[5:4]);
      end
      // Every width at every offset
      for (f = 0; f < 8; f++) begin
         for (o = 0; o < 4; o++) begin
            r = $urandom;
            drive(make_inst(opc_load, f[2:0], r[6:0]), o[1:0]);
            drive(make_inst(opc_store, f[2:0], r[14:8]), o[1:0]);
         end
      end
      for (f = 0; f < 8; f++) begin
         r = $urandom;
         drive(make_inst(opc_branch, f[2:0], r[6:0]), r[9:8]);
         drive(make_inst(opc_jal, f[2:0], r[16:10]), r[9:8]);
         drive(make_inst(opc_jalr, f[2:0], r[24:18]), r[9:8]);
      end
      // ECALL, EBREAK, MRET and bad funct7 values
      w = make_inst(opc_system, 3'b000, 7'h00);
      w[20] = 1'b0;
      drive(w, 2'b00);
      w[20] = 1'b1;
      drive(w, 2'b01);
      drive(make_inst(opc_system, 3'b000, 7'h18), 2'b10);
      drive(make_inst(opc_system, 3'b000, 7'h7F), 2'b11);
      drive(make_inst(opc_system, 3'b000, 7'h01), 2'b00);
      for (f = 1; f < 8; f++) begin
         r = $urandom;
         drive(make_inst(opc_system, f[2:0], r[6:0]), r[9:8]);
      end
      // Sweep of all opcode values
      for (f = 0; f < 32; f++) begin
         r = $urandom;
         drive(make_inst(f[4:0], r[2:0], r[9:3]), r[11:10]);
      end
      for (k = 0; k < 2000; k++) begin
         r = $urandom;
         drive($urandom, r[1:0]);
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* instruction_decoder.f */
+incdir+include
logic/rv32i_decode_pkg.sv
logic/inst_fields_if.sv
logic/inst_field_decode.sv
logic/alu_ctrl_decode.sv
logic/mem_access_decode.sv
logic/flow_sys_decode.sv
logic/instruction_decoder.sv
testbench/tb_clock_gen.sv
testbench/tb_instruction_decoder.sv
